//--- dv/mul_unit_tb.sv
// Directed testbench for mul_unit; needs timing support, expected values come from a 128-bit model.
`timescale 1ns/1ps

module mul_unit_tb;

    localparam int SEED         = 88314;
    localparam int LATENCY      = 66;
    localparam int DONE_TIMEOUT = 200;
    localparam int RANDOM_OPS   = 200;

    logic                     clk;
    logic                     rst_n;
    logic                     start;
    mul_pkg::mul_op_e         op;
    logic [mul_pkg::XLEN-1:0] op_a;
    logic [mul_pkg::XLEN-1:0] op_b;
    logic                     busy;
    logic                     done;
    logic [mul_pkg::XLEN-1:0] result;

    int checks;
    int mismatches;
    int timeouts;
    bit hung;

    mul_unit mul_unit_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .op     (op),
        .op_a   (op_a),
        .op_b   (op_b),
        .busy   (busy),
        .done   (done),
        .result (result)
    );

    always #2 clk = ~clk;

    // Full product of the extended operands, then the slice for the opcode.
    function automatic logic [mul_pkg::XLEN-1:0] model_result(input mul_pkg::mul_op_e op_m,
            input logic [mul_pkg::XLEN-1:0] a, input logic [mul_pkg::XLEN-1:0] b);
        logic [mul_pkg::PROD_W-1:0] ext_a;
        logic [mul_pkg::PROD_W-1:0] ext_b;
        logic [mul_pkg::PROD_W-1:0] prod;
        logic                       a_sig;
        logic                       b_sig;
        a_sig = (op_m != mul_pkg::OP_MULHU);
        b_sig = (op_m != mul_pkg::OP_MULHU) && (op_m != mul_pkg::OP_MULHSU);
        if (op_m == mul_pkg::OP_MULW) begin
            ext_a = {{96{a[31]}}, a[31:0]};
            ext_b = {{96{b[31]}}, b[31:0]};
        end else begin
            ext_a = {{64{a_sig & a[63]}}, a};
            ext_b = {{64{b_sig & b[63]}}, b};
        end
        prod = ext_a * ext_b;
        case (op_m)
            mul_pkg::OP_MUL:  return prod[63:0];
            mul_pkg::OP_MULW: return {{32{prod[31]}}, prod[31:0]};
            default:          return prod[127:64];
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks.
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_result(input string name, input logic [mul_pkg::XLEN-1:0] expected,
                                input logic [mul_pkg::XLEN-1:0] actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            mismatches++;
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // One operation; a second start is pushed at edge inject_at when it is non-zero.
    task automatic run_op(input string name, input mul_pkg::mul_op_e op_s,
                          input logic [mul_pkg::XLEN-1:0] a, input logic [mul_pkg::XLEN-1:0] b,
                          input logic [mul_pkg::XLEN-1:0] expected, input int inject_at);
        logic [mul_pkg::XLEN-1:0] held;
        int                       cycles;
        if (!hung) begin
            @(negedge clk);
            held = result;
            start = 1'b1;
            op = op_s;
            op_a = a;
            op_b = b;
            cycles = 0;
            // The first edge counted is the one that samples start.
            do begin
                @(posedge clk);
                cycles++;
                @(negedge clk);
                start = (cycles == inject_at);
                // Inputs past the start cycle are junk.
                op = mul_pkg::mul_op_e'($urandom_range(4, 0));
                op_a = {$urandom(), $urandom()};
                op_b = {$urandom(), $urandom()};
                if (!done) begin
                    check_flag({name, " busy"}, 1'b1, busy);
                    check_result({name, " held"}, held, result);
                end
            end while (!done && cycles < DONE_TIMEOUT);
            start = 1'b0;
            if (!done) begin
                timeouts++;
                hung = 1'b1;
                $display("Timeout: %s got no done within %0d cycles", name, DONE_TIMEOUT);
            end else begin
                check_latency({name, " latency"}, LATENCY, cycles);
                check_result(name, expected, result);
                check_flag({name, " busy at done"}, 1'b0, busy);
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests.
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        repeat (3) begin
            @(negedge clk);
            check_flag("reset busy", 1'b0, busy);
            check_flag("reset done", 1'b0, done);
            check_result("reset result", '0, result);
        end
    endtask

    task automatic test_corner_operands();
        logic [mul_pkg::XLEN-1:0] vals [9];
        mul_pkg::mul_op_e         op_c;
        vals = '{64'h0, 64'h1, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000,
                 64'h7fff_ffff_ffff_ffff, 64'h0000_0000_ffff_ffff, 64'h0000_0001_0000_0000,
                 64'h0000_0000_8000_0000, 64'h0000_0000_7fff_ffff};
        for (int k = 0; k < 5; k++) begin
            op_c = mul_pkg::mul_op_e'(k);
            for (int i = 0; i < 9; i++) begin
                for (int j = 0; j < 9; j++) begin
                    run_op($sformatf("corner %s %h %h", op_c.name(), vals[i], vals[j]),
                           op_c, vals[i], vals[j], model_result(op_c, vals[i], vals[j]), 0);
                end
            end
        end
    endtask

    // Upper operand words are junk and must not matter.
    task automatic test_mulw_sign_extension();
        run_op("mulw bit31 set", mul_pkg::OP_MULW, 64'hdead_beef_0001_0000,
               64'h1234_5678_0000_8000, 64'hffff_ffff_8000_0000, 0);
        run_op("mulw bit31 clear", mul_pkg::OP_MULW, 64'hcafe_f00d_0000_0003,
               64'hffff_0000_0000_0005, 64'h0000_0000_0000_000f, 0);
    endtask

    task automatic test_latency_and_strobes();
        check_flag("idle busy", 1'b0, busy);
        run_op("latency", mul_pkg::OP_MULHU, '1, '1, 64'hffff_ffff_ffff_fffe, 0);
        @(negedge clk);
        check_flag("done width", 1'b0, done);
        check_flag("busy after done", 1'b0, busy);
    endtask

    task automatic test_start_while_busy();
        logic [mul_pkg::XLEN-1:0] a;
        logic [mul_pkg::XLEN-1:0] b;
        logic [mul_pkg::XLEN-1:0] held;
        a = 64'h8000_0000_0000_0001;
        b = 64'h1234_5678_9abc_def0;
        run_op("start while busy", mul_pkg::OP_MULH, a, b,
               model_result(mul_pkg::OP_MULH, a, b), 20);
        held = result;
        repeat (80) begin
            @(negedge clk);
            check_flag("extra done", 1'b0, done);
            check_result("result hold", held, result);
        end
    endtask

    task automatic test_random_regression();
        mul_pkg::mul_op_e         op_r;
        logic [mul_pkg::XLEN-1:0] a;
        logic [mul_pkg::XLEN-1:0] b;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            op_r = mul_pkg::mul_op_e'($urandom_range(4, 0));
            a = {$urandom(), $urandom()};
            b = {$urandom(), $urandom()};
            run_op($sformatf("random %0d %s", n, op_r.name()), op_r, a, b,
                   model_result(op_r, a, b), 0);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        op = mul_pkg::OP_MUL;
        op_a = '0;
        op_b = '0;
        checks = 0;
        mismatches = 0;
        timeouts = 0;
        hung = 1'b0;
        void'($urandom(SEED));
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_corner_operands();
        test_mulw_sign_extension();
        test_latency_and_strobes();
        test_start_while_busy();
        test_random_regression();
        $display("Checks: %0d, mismatches: %0d, timeouts: %0d", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
logic/mul_pkg.sv
logic/mul_ctrl.sv
logic/mul_step_counter.sv
logic/mul_operand_prep.sv
logic/mul_shift_add.sv
logic/mul_result_format.sv
logic/mul_unit.sv
dv/mul_unit_tb.sv

//--- logic/mul_ctrl.sv
// Multiply sequencer; start is only seen in idle, operands are taken on the accepting edge.
`timescale 1ns/1ps

module mul_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic last_step,
    output logic load,
    output logic step_en,
    output logic capture,
    output logic busy,
    output logic done
);

    mul_pkg::ctrl_state_e state;
    mul_pkg::ctrl_state_e state_nxt;

    ////////////////////////////////////////////////////////////////////////////
    // State register and next state.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mul_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            mul_pkg::ST_IDLE: begin
                if (start) begin
                    state_nxt = mul_pkg::ST_LOAD;
                end
            end
            // Datapath seeds from the registered magnitudes here.
            mul_pkg::ST_LOAD: state_nxt = mul_pkg::ST_RUN;
            mul_pkg::ST_RUN: begin
                if (last_step) begin
                    state_nxt = mul_pkg::ST_DONE;
                end
            end
            mul_pkg::ST_DONE: state_nxt = mul_pkg::ST_IDLE;
            default:          state_nxt = mul_pkg::ST_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Strobes.
    ////////////////////////////////////////////////////////////////////////////

    // Load goes with the accepted start, while the operands are still valid.
    assign load    = (state == mul_pkg::ST_IDLE) && start;
    assign step_en = (state == mul_pkg::ST_RUN);
    // Result is taken on the edge that ends the last step.
    assign capture = step_en && last_step;
    assign busy    = (state == mul_pkg::ST_LOAD) || (state == mul_pkg::ST_RUN);
    assign done    = (state == mul_pkg::ST_DONE);

    // Done is a single-cycle strobe.
    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done);

    // Never seed the datapath in the middle of a run.
    assert property (@(posedge clk) disable iff (!rst_n) !(step_en && load));

endmodule

//--- logic/mul_operand_prep.sv
// Operand front end; takes op_a, op_b and op only in the load cycle and holds them until the next load.
`timescale 1ns/1ps

module mul_operand_prep (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  mul_pkg::mul_op_e         op,
    input  logic [mul_pkg::XLEN-1:0] op_a,
    input  logic [mul_pkg::XLEN-1:0] op_b,
    output logic [mul_pkg::XLEN-1:0] mag_a,
    output logic [mul_pkg::XLEN-1:0] mag_b,
    output logic                     neg_result,
    output mul_pkg::mul_op_e         op_q
);

    logic [mul_pkg::XLEN-1:0] a_ext;
    logic [mul_pkg::XLEN-1:0] b_ext;
    logic                     a_signed;
    logic                     b_signed;
    logic                     a_neg;
    logic                     b_neg;

    // Widening and signedness per opcode.
    always_comb begin
        a_ext    = op_a;
        b_ext    = op_b;
        a_signed = 1'b1;
        b_signed = 1'b1;
        case (op)
            mul_pkg::OP_MULW: begin
                a_ext = {{(mul_pkg::XLEN - mul_pkg::WORD_W){op_a[mul_pkg::WORD_W-1]}},
                         op_a[mul_pkg::WORD_W-1:0]};
                b_ext = {{(mul_pkg::XLEN - mul_pkg::WORD_W){op_b[mul_pkg::WORD_W-1]}},
                         op_b[mul_pkg::WORD_W-1:0]};
            end
            mul_pkg::OP_MULHSU: b_signed = 1'b0;
            mul_pkg::OP_MULHU: begin
                a_signed = 1'b0;
                b_signed = 1'b0;
            end
            default: begin
                a_signed = 1'b1;
                b_signed = 1'b1;
            end
        endcase
    end

    assign a_neg = a_signed && a_ext[mul_pkg::XLEN-1];
    assign b_neg = b_signed && b_ext[mul_pkg::XLEN-1];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            neg_result <= 1'b0;
            op_q       <= mul_pkg::OP_MUL;
        end else if (load) begin
            neg_result <= a_neg ^ b_neg;
            op_q       <= op;
        end
    end

    // Most negative input maps to 2**63, which still fits unsigned.
    always_ff @(posedge clk) begin
        if (load) begin
            mag_a <= a_neg ? (~a_ext + 1'b1) : a_ext;
            mag_b <= b_neg ? (~b_ext + 1'b1) : b_ext;
        end
    end

endmodule

//--- logic/mul_pkg.sv
// Shared widths and encodings for the RV64M multiply unit; XLEN is fixed at 64 and not tunable.
package mul_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths.
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 64;
    localparam int WORD_W     = 32;
    localparam int PROD_W     = 128;

    // One shift-add step per multiplier bit.
    localparam int STEP_COUNT = 64;
    localparam int STEP_CNT_W = 7;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings.
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_MULW   = 3'd4
    } mul_op_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_LOAD = 2'd1,
        ST_RUN  = 2'd2,
        ST_DONE = 2'd3
    } ctrl_state_e;

endpackage

//--- logic/mul_result_format.sv
// Result stage; result changes only on capture and holds until the next one.
`timescale 1ns/1ps

module mul_result_format (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       capture,
    input  mul_pkg::mul_op_e           op_q,
    input  logic                       neg_result,
    input  logic [mul_pkg::PROD_W-1:0] product,
    output logic [mul_pkg::XLEN-1:0]   result
);

    logic [mul_pkg::PROD_W-1:0] signed_prod;
    logic [mul_pkg::XLEN-1:0]   slice;

    // Two's-complement over the full width, so the high half is right too.
    assign signed_prod = neg_result ? (~product + 1'b1) : product;

    always_comb begin
        case (op_q)
            mul_pkg::OP_MUL: begin
                slice = signed_prod[mul_pkg::XLEN-1:0];
            end
            mul_pkg::OP_MULH, mul_pkg::OP_MULHSU, mul_pkg::OP_MULHU: begin
                slice = signed_prod[mul_pkg::PROD_W-1:mul_pkg::XLEN];
            end
            mul_pkg::OP_MULW: begin
                slice = {{(mul_pkg::XLEN - mul_pkg::WORD_W){signed_prod[mul_pkg::WORD_W-1]}},
                         signed_prod[mul_pkg::WORD_W-1:0]};
            end
            default: begin
                slice = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (capture) begin
            result <= slice;
        end
    end

endmodule

//--- logic/mul_shift_add.sv
// Radix-2 shift-add core; always runs the full step count, product is valid on the last step.
`timescale 1ns/1ps

module mul_shift_add (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       load,
    input  logic                       step_en,
    input  logic [mul_pkg::XLEN-1:0]   mag_a,
    input  logic [mul_pkg::XLEN-1:0]   mag_b,
    output logic [mul_pkg::PROD_W-1:0] product
);

    logic                       seed;
    logic [mul_pkg::PROD_W-1:0] mcand;
    logic [mul_pkg::XLEN-1:0]   mplier;
    logic [mul_pkg::PROD_W-1:0] acc;
    logic [mul_pkg::PROD_W-1:0] addend;
    logic [mul_pkg::PROD_W:0]   sum;

    // Magnitudes land one edge after load, so seed on the following one.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seed <= 1'b0;
        end else begin
            seed <= load;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Shift-add registers.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (seed) begin
            mcand  <= {{(mul_pkg::PROD_W - mul_pkg::XLEN){1'b0}}, mag_a};
            mplier <= mag_b;
            acc    <= '0;
        end else if (step_en) begin
            mcand  <= {mcand[mul_pkg::PROD_W-2:0], 1'b0};
            mplier <= {1'b0, mplier[mul_pkg::XLEN-1:1]};
            acc    <= sum[mul_pkg::PROD_W-1:0];
        end
    end

    assign addend = mplier[0] ? mcand : '0;
    assign sum    = {1'b0, acc} + {1'b0, addend};

    // Next accumulator value while stepping, so the final sum is visible on the last step.
    assign product = step_en ? sum[mul_pkg::PROD_W-1:0] : acc;

    // Product of two 64-bit magnitudes always fits in 128 bits.
    assert property (@(posedge clk) disable iff (!rst_n) step_en |-> !sum[mul_pkg::PROD_W]);

endmodule

//--- logic/mul_step_counter.sv
// Step counter for the shift-add loop; assumes load precedes every run of enabled steps.
`timescale 1ns/1ps

module mul_step_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic step_en,
    output logic last_step
);

    logic [mul_pkg::STEP_CNT_W-1:0] step_cnt;

    // Counts down the remaining steps.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_cnt <= '0;
        end else if (load) begin
            step_cnt <= mul_pkg::STEP_CNT_W'(mul_pkg::STEP_COUNT);
        end else if (step_en) begin
            step_cnt <= step_cnt - 1'b1;
        end
    end

    assign last_step = step_en && (step_cnt == mul_pkg::STEP_CNT_W'(1));

    // The sequencer must leave the run before the count runs out.
    assert property (@(posedge clk) disable iff (!rst_n) step_en |-> (step_cnt != '0));

endmodule

//--- logic/mul_unit.sv
// RV64M multiply unit; done follows start by a fixed 66 edges, starts while busy are dropped.
`timescale 1ns/1ps

module mul_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  mul_pkg::mul_op_e         op,
    input  logic [mul_pkg::XLEN-1:0] op_a,
    input  logic [mul_pkg::XLEN-1:0] op_b,
    output logic                     busy,
    output logic                     done,
    output logic [mul_pkg::XLEN-1:0] result
);

    logic                       load;
    logic                       step_en;
    logic                       capture;
    logic                       last_step;
    logic [mul_pkg::XLEN-1:0]   mag_a;
    logic [mul_pkg::XLEN-1:0]   mag_b;
    logic                       neg_result;
    mul_pkg::mul_op_e           op_q;
    logic [mul_pkg::PROD_W-1:0] product;

    ////////////////////////////////////////////////////////////////////////////
    // Control.
    ////////////////////////////////////////////////////////////////////////////

    mul_ctrl mul_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .last_step (last_step),
        .load      (load),
        .step_en   (step_en),
        .capture   (capture),
        .busy      (busy),
        .done      (done)
    );

    mul_step_counter mul_step_counter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .step_en   (step_en),
        .last_step (last_step)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Datapath.
    ////////////////////////////////////////////////////////////////////////////

    mul_operand_prep mul_operand_prep_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .load       (load),
        .op         (op),
        .op_a       (op_a),
        .op_b       (op_b),
        .mag_a      (mag_a),
        .mag_b      (mag_b),
        .neg_result (neg_result),
        .op_q       (op_q)
    );

    mul_shift_add mul_shift_add_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .step_en (step_en),
        .mag_a   (mag_a),
        .mag_b   (mag_b),
        .product (product)
    );

    mul_result_format mul_result_format_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .capture    (capture),
        .op_q       (op_q),
        .neg_result (neg_result),
        .product    (product),
        .result     (result)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it, and exits non-zero unless it passed.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module mul_unit_tb -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vmul_unit_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
